// ==== hdl/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// datapath widths
`define MIPS_WORD_W      32
`define MIPS_REG_ADDR_W  5
`define MIPS_ALU_OP_W    4

// first fetch address after reset
`define MIPS_RESET_PC    32'h0000_0000

// ==================================================
// opcodes, instr[31:26]
// ==================================================
`define MIPS_OP_RTYPE    6'b000000
`define MIPS_OP_BEQ      6'b000100
`define MIPS_OP_BNE      6'b000101
`define MIPS_OP_ADDIU    6'b001001
`define MIPS_OP_ANDI     6'b001100
`define MIPS_OP_ORI      6'b001101
`define MIPS_OP_LUI      6'b001111
`define MIPS_OP_LW       6'b100011
`define MIPS_OP_SW       6'b101011

// funct codes for R-type, instr[5:0]
`define MIPS_FN_SLL      6'b000000
`define MIPS_FN_SRL      6'b000010
`define MIPS_FN_ADDU     6'b100001
`define MIPS_FN_SUBU     6'b100011
`define MIPS_FN_AND      6'b100100
`define MIPS_FN_OR       6'b100101
`define MIPS_FN_XOR      6'b100110
`define MIPS_FN_NOR      6'b100111
`define MIPS_FN_SLT      6'b101010
`define MIPS_FN_SLTU     6'b101011

// ==================================================
// ALU operation codes
// ==================================================
`define MIPS_ALU_ADD     4'd0
`define MIPS_ALU_SUB     4'd1
`define MIPS_ALU_AND     4'd2
`define MIPS_ALU_OR      4'd3
`define MIPS_ALU_XOR     4'd4
`define MIPS_ALU_NOR     4'd5
`define MIPS_ALU_SLT     4'd6
`define MIPS_ALU_SLTU    4'd7
`define MIPS_ALU_SLL     4'd8
`define MIPS_ALU_SRL     4'd9
`define MIPS_ALU_LUI     4'd10

// execute-stage operand forwarding selects
`define MIPS_FWD_NONE    2'b00
`define MIPS_FWD_WB      2'b01
`define MIPS_FWD_MEM     2'b10

`endif

// ==== hdl/mipsPkg.sv ====
`default_nettype none

`include "mips_macros.svh"

package mipsPkg;

	// data word or byte address
	typedef logic [`MIPS_WORD_W-1:0] word_t;
	// register number
	typedef logic [`MIPS_REG_ADDR_W-1:0] regAddr_t;
	typedef logic [`MIPS_ALU_OP_W-1:0] aluOp_t;

	// ==================================================
	// decoded control
	// ==================================================
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		// second ALU operand is the immediate
		logic aluSrcImm;
		// destination is rd, else rt
		logic regDst;
		logic branchEq;
		logic branchNe;
		// operand usage, for hazard detection
		logic usesRs;
		logic usesRt;
		aluOp_t aluOp;
	} ctrlBundle_t;

	// ==================================================
	// stage registers
	// ==================================================
	typedef struct packed {
		ctrlBundle_t ctrl;
		word_t rsVal;
		word_t rtVal;
		word_t imm;
		logic [4:0] shamt;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		word_t pc;
	} idExReg_t;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		word_t aluResult;
		word_t storeData;
		regAddr_t dest;
		word_t pc;
	} exMemReg_t;

	// result already picked between load data and ALU output
	typedef struct packed {
		logic regWrite;
		word_t result;
		regAddr_t dest;
		word_t pc;
	} memWbReg_t;

	// one retiring register write
	typedef struct packed {
		word_t pc;
		regAddr_t dest;
		word_t data;
	} wbPort_t;

endpackage

`default_nettype wire

// ==== hdl/controlDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips_macros.svh"

module controlDecoder (
	input  mipsPkg::word_t       instr,
	output mipsPkg::ctrlBundle_t ctrl,
	output mipsPkg::word_t       imm
);

	logic [5:0] opcode;
	logic [5:0] funct;
	// the three immediate forms
	mipsPkg::word_t signImm;
	mipsPkg::word_t zeroImm;
	mipsPkg::word_t upperImm;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	assign signImm = {{16{instr[15]}}, instr[15:0]};
	assign zeroImm = {16'b0, instr[15:0]};
	assign upperImm = {instr[15:0], 16'b0};

	// ==================================================
	// opcode / funct decode
	// ==================================================
	always_comb begin
		// unknown encodings fall through as a bubble
		ctrl = '0;
		imm = signImm;
		case (opcode)
			`MIPS_OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				ctrl.usesRs = 1'b1;
				ctrl.usesRt = 1'b1;
				case (funct)
					`MIPS_FN_ADDU: ctrl.aluOp = `MIPS_ALU_ADD;
					`MIPS_FN_SUBU: ctrl.aluOp = `MIPS_ALU_SUB;
					`MIPS_FN_AND: ctrl.aluOp = `MIPS_ALU_AND;
					`MIPS_FN_OR: ctrl.aluOp = `MIPS_ALU_OR;
					`MIPS_FN_XOR: ctrl.aluOp = `MIPS_ALU_XOR;
					`MIPS_FN_NOR: ctrl.aluOp = `MIPS_ALU_NOR;
					`MIPS_FN_SLT: ctrl.aluOp = `MIPS_ALU_SLT;
					`MIPS_FN_SLTU: ctrl.aluOp = `MIPS_ALU_SLTU;
					// shifts read rt only, amount from shamt
					`MIPS_FN_SLL: begin
						ctrl.aluOp = `MIPS_ALU_SLL;
						ctrl.usesRs = 1'b0;
					end
					`MIPS_FN_SRL: begin
						ctrl.aluOp = `MIPS_ALU_SRL;
						ctrl.usesRs = 1'b0;
					end
					default: ctrl = '0;
				endcase
			end
			`MIPS_OP_ADDIU: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.usesRs = 1'b1;
				ctrl.aluOp = `MIPS_ALU_ADD;
			end
			// logic immediates are zero extended
			`MIPS_OP_ANDI, `MIPS_OP_ORI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.usesRs = 1'b1;
				ctrl.aluOp = (opcode == `MIPS_OP_ANDI) ? `MIPS_ALU_AND : `MIPS_ALU_OR;
				imm = zeroImm;
			end
			`MIPS_OP_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = `MIPS_ALU_LUI;
				imm = upperImm;
			end
			// address = rs + signed offset
			`MIPS_OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.usesRs = 1'b1;
				ctrl.aluOp = `MIPS_ALU_ADD;
			end
			`MIPS_OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.usesRs = 1'b1;
				ctrl.usesRt = 1'b1;
				ctrl.aluOp = `MIPS_ALU_ADD;
			end
			// branches resolve in decode, no ALU use
			`MIPS_OP_BEQ, `MIPS_OP_BNE: begin
				ctrl.branchEq = (opcode == `MIPS_OP_BEQ);
				ctrl.branchNe = (opcode == `MIPS_OP_BNE);
				ctrl.usesRs = 1'b1;
				ctrl.usesRt = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input  logic               clk,
	input  logic               rstN,
	input  mipsPkg::regAddr_t  readAddrA,
	input  mipsPkg::regAddr_t  readAddrB,
	output mipsPkg::word_t     readDataA,
	output mipsPkg::word_t     readDataB,
	input  logic               writeEn,
	input  mipsPkg::regAddr_t  writeAddr,
	input  mipsPkg::word_t     writeData
);

	localparam int NumRegs = 2 ** $bits(mipsPkg::regAddr_t);

	mipsPkg::word_t regs [NumRegs];

	// r0 never written
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// read port, same-cycle write bypassed
	function automatic mipsPkg::word_t readPort(input mipsPkg::regAddr_t addr);
		if (addr == '0) begin
			return '0;
		end
		if (writeEn && (writeAddr == addr)) begin
			return writeData;
		end
		return regs[addr];
	endfunction

	assign readDataA = readPort(readAddrA);
	assign readDataB = readPort(readAddrB);

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips_macros.svh"

module alu (
	input  mipsPkg::aluOp_t op,
	input  mipsPkg::word_t  srcA,
	input  mipsPkg::word_t  srcB,
	input  logic [4:0]      shamt,
	output mipsPkg::word_t  result
);

	// set-less-than flags
	logic ltSigned;
	logic ltUnsigned;

	assign ltSigned = ($signed(srcA) < $signed(srcB));
	assign ltUnsigned = (srcA < srcB);

	always_comb begin
		case (op)
			// wrapping, no overflow trap
			`MIPS_ALU_ADD: result = srcA + srcB;
			`MIPS_ALU_SUB: result = srcA - srcB;
			`MIPS_ALU_AND: result = srcA & srcB;
			`MIPS_ALU_OR: result = srcA | srcB;
			`MIPS_ALU_XOR: result = srcA ^ srcB;
			`MIPS_ALU_NOR: result = ~(srcA | srcB);
			`MIPS_ALU_SLT: result = mipsPkg::word_t'(ltSigned);
			`MIPS_ALU_SLTU: result = mipsPkg::word_t'(ltUnsigned);
			// logical shifts act on rt
			`MIPS_ALU_SLL: result = srcB << shamt;
			`MIPS_ALU_SRL: result = srcB >> shamt;
			// immediate already shifted up by the decoder
			`MIPS_ALU_LUI: result = srcB;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/hazardUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips_macros.svh"

module hazardUnit (
	// decode; register numbers are zero when not read
	input  mipsPkg::regAddr_t rsD,
	input  mipsPkg::regAddr_t rtD,
	input  logic              branchD,
	// execute
	input  mipsPkg::regAddr_t rsE,
	input  mipsPkg::regAddr_t rtE,
	input  mipsPkg::regAddr_t destE,
	input  logic              regWriteE,
	input  logic              memToRegE,
	// memory
	input  mipsPkg::regAddr_t destM,
	input  logic              regWriteM,
	input  logic              memToRegM,
	// writeback
	input  mipsPkg::regAddr_t destW,
	input  logic              regWriteW,
	output logic [1:0]        forwardAE,
	output logic [1:0]        forwardBE,
	output logic              forwardAD,
	output logic              forwardBD,
	output logic              stallFD,
	output logic              flushE
);

	logic loadUseD;
	logic branchWaitD;

	// producer writes src, r0 excluded
	function automatic logic hits(
		input logic              we,
		input mipsPkg::regAddr_t dest,
		input mipsPkg::regAddr_t src
	);
		return we && (dest != '0) && (dest == src);
	endfunction

	// ==================================================
	// forwarding
	// ==================================================
	// memory stage is younger, so it wins
	assign forwardAE = hits(regWriteM, destM, rsE) ? `MIPS_FWD_MEM :
		hits(regWriteW, destW, rsE) ? `MIPS_FWD_WB : `MIPS_FWD_NONE;
	assign forwardBE = hits(regWriteM, destM, rtE) ? `MIPS_FWD_MEM :
		hits(regWriteW, destW, rtE) ? `MIPS_FWD_WB : `MIPS_FWD_NONE;

	// branch compare, ALU result from memory only
	// writeback is covered by the regfile bypass
	assign forwardAD = hits(regWriteM, destM, rsD);
	assign forwardBD = hits(regWriteM, destM, rtD);

	// ==================================================
	// stall / bubble
	// ==================================================
	// load in execute feeding decode
	assign loadUseD = hits(memToRegE, destE, rsD) || hits(memToRegE, destE, rtD);

	// branch operand still in execute, or a load in memory
	assign branchWaitD = branchD && (
		hits(regWriteE, destE, rsD) || hits(regWriteE, destE, rtD) ||
		hits(memToRegM, destM, rsD) || hits(memToRegM, destM, rtD));

	assign stallFD = loadUseD || branchWaitD;
	// held decode instr leaves a bubble behind
	assign flushE = stallFD;

endmodule

`default_nettype wire

// ==== hdl/mipsPipeline.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips_macros.svh"

module mipsPipeline (
	input  logic             clk,
	input  logic             rstN,
	// instruction memory, combinational
	output mipsPkg::word_t   imemAddr,
	input  mipsPkg::word_t   imemData,
	// data memory, combinational read
	output mipsPkg::word_t   dmemAddr,
	output mipsPkg::word_t   dmemWriteData,
	output logic             dmemWe,
	input  mipsPkg::word_t   dmemReadData,
	// retirement
	output logic             wbValid,
	output mipsPkg::wbPort_t wbInfo
);

	// fetch/decode register, only used here
	typedef struct packed {
		mipsPkg::word_t instr;
		mipsPkg::word_t pc;
	} ifIdReg_t;

	// fetch
	mipsPkg::word_t pcF;
	mipsPkg::word_t pcPlus4F;
	mipsPkg::word_t pcNextF;
	ifIdReg_t ifIdQ;

	// decode
	mipsPkg::ctrlBundle_t ctrlD;
	mipsPkg::word_t immD;
	mipsPkg::regAddr_t rsD;
	mipsPkg::regAddr_t rtD;
	mipsPkg::regAddr_t rdD;
	mipsPkg::regAddr_t rsUsedD;
	mipsPkg::regAddr_t rtUsedD;
	mipsPkg::word_t rfDataA;
	mipsPkg::word_t rfDataB;
	mipsPkg::word_t cmpA;
	mipsPkg::word_t cmpB;
	mipsPkg::word_t pcPlus4D;
	mipsPkg::word_t branchTargetD;
	logic branchD;
	logic branchTakenD;
	logic forwardAD;
	logic forwardBD;
	logic stallFD;
	logic flushE;
	mipsPkg::idExReg_t idExD;
	mipsPkg::idExReg_t idExQ;

	// execute
	mipsPkg::regAddr_t destE;
	logic [1:0] forwardAE;
	logic [1:0] forwardBE;
	mipsPkg::word_t srcAE;
	mipsPkg::word_t fwdBE;
	mipsPkg::word_t srcBE;
	mipsPkg::word_t aluResultE;
	mipsPkg::exMemReg_t exMemD;
	mipsPkg::exMemReg_t exMemQ;

	// memory / writeback
	mipsPkg::memWbReg_t memWbD;
	mipsPkg::memWbReg_t memWbQ;

	// ==================================================
	// fetch
	// ==================================================
	assign imemAddr = pcF;
	assign pcPlus4F = pcF + 32'd4;
	// taken branch lands after the delay slot now in fetch
	assign pcNextF = branchTakenD ? branchTargetD : pcPlus4F;

	// stall holds pc and the fetch/decode register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pcF <= `MIPS_RESET_PC;
			// all-zero word is a nop
			ifIdQ.instr <= '0;
		end else if (!stallFD) begin
			pcF <= pcNextF;
			ifIdQ.instr <= imemData;
			ifIdQ.pc <= pcF;
		end
	end

	// ==================================================
	// decode
	// ==================================================
	assign rsD = ifIdQ.instr[25:21];
	assign rtD = ifIdQ.instr[20:16];
	assign rdD = ifIdQ.instr[15:11];

	controlDecoder controlDecoder_i (
		.instr (ifIdQ.instr),
		.ctrl  (ctrlD),
		.imm   (immD)
	);

	// writeback port of the regfile
	regFile regFile_i (
		.clk       (clk),
		.rstN      (rstN),
		.readAddrA (rsD),
		.readAddrB (rtD),
		.readDataA (rfDataA),
		.readDataB (rfDataB),
		.writeEn   (memWbQ.regWrite),
		.writeAddr (memWbQ.dest),
		.writeData (memWbQ.result)
	);

	// hide fields the instr does not read
	assign rsUsedD = ctrlD.usesRs ? rsD : '0;
	assign rtUsedD = ctrlD.usesRt ? rtD : '0;

	// branch compare with memory-stage forwarding
	assign cmpA = forwardAD ? exMemQ.aluResult : rfDataA;
	assign cmpB = forwardBD ? exMemQ.aluResult : rfDataB;
	assign branchD = ctrlD.branchEq | ctrlD.branchNe;
	assign branchTakenD = (ctrlD.branchEq && (cmpA == cmpB)) ||
		(ctrlD.branchNe && (cmpA != cmpB));

	// target relative to the delay slot
	assign pcPlus4D = ifIdQ.pc + 32'd4;
	assign branchTargetD = pcPlus4D + {immD[29:0], 2'b00};

	always_comb begin
		// bubble on stall
		idExD.ctrl = flushE ? '0 : ctrlD;
		idExD.rsVal = rfDataA;
		idExD.rtVal = rfDataB;
		idExD.imm = immD;
		idExD.shamt = ifIdQ.instr[10:6];
		idExD.rs = rsD;
		idExD.rt = rtD;
		idExD.rd = rdD;
		idExD.pc = ifIdQ.pc;
	end

	hazardUnit hazardUnit_i (
		.rsD       (rsUsedD),
		.rtD       (rtUsedD),
		.branchD   (branchD),
		.rsE       (idExQ.rs),
		.rtE       (idExQ.rt),
		.destE     (destE),
		.regWriteE (idExQ.ctrl.regWrite),
		.memToRegE (idExQ.ctrl.memToReg),
		.destM     (exMemQ.dest),
		.regWriteM (exMemQ.regWrite),
		.memToRegM (exMemQ.memToReg),
		.destW     (memWbQ.dest),
		.regWriteW (memWbQ.regWrite),
		.forwardAE (forwardAE),
		.forwardBE (forwardBE),
		.forwardAD (forwardAD),
		.forwardBD (forwardBD),
		.stallFD   (stallFD),
		.flushE    (flushE)
	);

	// ==================================================
	// execute
	// ==================================================
	// operand pick per forwarding select
	function automatic mipsPkg::word_t fwdPick(
		input logic [1:0]     sel,
		input mipsPkg::word_t regVal,
		input mipsPkg::word_t memVal,
		input mipsPkg::word_t wbVal
	);
		case (sel)
			`MIPS_FWD_MEM: return memVal;
			`MIPS_FWD_WB: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign destE = idExQ.ctrl.regDst ? idExQ.rd : idExQ.rt;
	assign srcAE = fwdPick(forwardAE, idExQ.rsVal, exMemQ.aluResult, memWbQ.result);
	// forwarded rt is also the store data
	assign fwdBE = fwdPick(forwardBE, idExQ.rtVal, exMemQ.aluResult, memWbQ.result);
	assign srcBE = idExQ.ctrl.aluSrcImm ? idExQ.imm : fwdBE;

	alu alu_i (
		.op     (idExQ.ctrl.aluOp),
		.srcA   (srcAE),
		.srcB   (srcBE),
		.shamt  (idExQ.shamt),
		.result (aluResultE)
	);

	always_comb begin
		exMemD.regWrite = idExQ.ctrl.regWrite;
		exMemD.memToReg = idExQ.ctrl.memToReg;
		exMemD.memWrite = idExQ.ctrl.memWrite;
		exMemD.aluResult = aluResultE;
		exMemD.storeData = fwdBE;
		exMemD.dest = destE;
		exMemD.pc = idExQ.pc;
	end

	// ==================================================
	// memory
	// ==================================================
	assign dmemAddr = exMemQ.aluResult;
	assign dmemWriteData = exMemQ.storeData;
	assign dmemWe = exMemQ.memWrite;

	// writeback result: load data or ALU output
	always_comb begin
		memWbD.regWrite = exMemQ.regWrite;
		memWbD.result = exMemQ.memToReg ? dmemReadData : exMemQ.aluResult;
		memWbD.dest = exMemQ.dest;
		memWbD.pc = exMemQ.pc;
	end

	// later stages always advance
	always_ff @(posedge clk) begin
		if (!rstN) begin
			idExQ.ctrl <= '0;
			exMemQ.regWrite <= 1'b0;
			exMemQ.memToReg <= 1'b0;
			exMemQ.memWrite <= 1'b0;
			memWbQ.regWrite <= 1'b0;
		end else begin
			idExQ <= idExD;
			exMemQ <= exMemD;
			memWbQ <= memWbD;
		end
	end

	// ==================================================
	// writeback / retirement
	// ==================================================
	// nops and r0 writes do not retire
	assign wbValid = memWbQ.regWrite && (memWbQ.dest != '0);

	always_comb begin
		wbInfo.pc = memWbQ.pc;
		wbInfo.dest = memWbQ.dest;
		wbInfo.data = memWbQ.result;
	end

endmodule

`default_nettype wire

// ==== testbench/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// in-order reference model, included inside the testbench module
// uses imem, fillWord, ImemWords, DmemWords and ProgLen from the includer

// one expected data-memory write
typedef struct packed {
	mipsPkg::word_t addr;
	mipsPkg::word_t data;
} storeRec_t;

// architectural state
mipsPkg::word_t modelRegs [32];
mipsPkg::word_t modelMem [DmemWords];

// expected DUT activity in program order
mipsPkg::wbPort_t expRetQ [$];
storeRec_t expStoreQ [$];

// ==================================================
// one instruction at pc
// ==================================================
task automatic execInstr(
	input  mipsPkg::word_t pc,
	output logic           isBranch,
	output logic           taken,
	output mipsPkg::word_t target
);
	mipsPkg::word_t instr;
	mipsPkg::word_t a;
	mipsPkg::word_t b;
	mipsPkg::word_t immS;
	mipsPkg::word_t immZ;
	mipsPkg::word_t addr;
	mipsPkg::word_t result;
	mipsPkg::regAddr_t dest;
	logic writes;
	storeRec_t st;
	mipsPkg::wbPort_t ret;
	// past the end of instruction memory reads as nop
	instr = (pc < ImemWords * 4) ? imem[pc[9:2]] : '0;
	a = modelRegs[instr[25:21]];
	b = modelRegs[instr[20:16]];
	immS = {{16{instr[15]}}, instr[15:0]};
	immZ = {16'b0, instr[15:0]};
	addr = a + immS;
	result = '0;
	// I-type writes rt
	dest = instr[20:16];
	writes = 1'b1;
	isBranch = 1'b0;
	taken = 1'b0;
	target = pc + 32'd8;
	case (instr[31:26])
		`MIPS_OP_RTYPE: begin
			dest = instr[15:11];
			case (instr[5:0])
				`MIPS_FN_ADDU: result = a + b;
				`MIPS_FN_SUBU: result = a - b;
				`MIPS_FN_AND: result = a & b;
				`MIPS_FN_OR: result = a | b;
				`MIPS_FN_XOR: result = a ^ b;
				`MIPS_FN_NOR: result = ~(a | b);
				`MIPS_FN_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				`MIPS_FN_SLTU: result = (a < b) ? 32'd1 : 32'd0;
				`MIPS_FN_SLL: result = b << instr[10:6];
				`MIPS_FN_SRL: result = b >> instr[10:6];
				default: writes = 1'b0;
			endcase
		end
		`MIPS_OP_ADDIU: result = a + immS;
		`MIPS_OP_ANDI: result = a & immZ;
		`MIPS_OP_ORI: result = a | immZ;
		`MIPS_OP_LUI: result = {instr[15:0], 16'b0};
		`MIPS_OP_LW: result = modelMem[addr[7:2]];
		`MIPS_OP_SW: begin
			writes = 1'b0;
			st.addr = addr;
			st.data = b;
			expStoreQ.push_back(st);
			modelMem[addr[7:2]] = b;
		end
		// compare uses values from before the delay slot
		`MIPS_OP_BEQ, `MIPS_OP_BNE: begin
			writes = 1'b0;
			isBranch = 1'b1;
			taken = (instr[31:26] == `MIPS_OP_BEQ) ? (a == b) : (a != b);
			target = pc + 32'd4 + (immS << 2);
		end
		default: writes = 1'b0;
	endcase
	// r0 writes are dropped and never retire
	if (writes && (dest != '0)) begin
		modelRegs[dest] = result;
		ret.pc = pc;
		ret.dest = dest;
		ret.data = result;
		expRetQ.push_back(ret);
	end
endtask

// ==================================================
// whole program, delay slots included
// ==================================================
task automatic runModel();
	mipsPkg::word_t pc;
	mipsPkg::word_t target;
	mipsPkg::word_t slotTarget;
	logic isBranch;
	logic taken;
	logic slotBranch;
	logic slotTaken;
	for (int r = 0; r < 32; r++) begin
		modelRegs[r] = '0;
	end
	for (int w = 0; w < DmemWords; w++) begin
		modelMem[w] = fillWord(w);
	end
	pc = `MIPS_RESET_PC;
	// branches only go forward, so this ends
	while (pc < ProgLen * 4) begin
		execInstr(pc, isBranch, taken, target);
		if (isBranch) begin
			// delay slot always runs
			execInstr(pc + 32'd4, slotBranch, slotTaken, slotTarget);
			pc = taken ? target : pc + 32'd8;
		end else begin
			pc = pc + 32'd4;
		end
	end
endtask

`endif

// ==== testbench/mipsPipelineTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips_macros.svh"

module mipsPipelineTb;

	localparam int ProgLen = 200;
	// index bits [9:2] of the fetch address
	localparam int ImemWords = 256;
	// 256 bytes indexed by bits [7:2]
	localparam int DmemWords = 64;
	localparam int Timeout = 5000;

	logic clk;
	logic rstN;
	mipsPkg::word_t imemAddr;
	mipsPkg::word_t imemData;
	mipsPkg::word_t dmemAddr;
	mipsPkg::word_t dmemWriteData;
	logic dmemWe;
	mipsPkg::word_t dmemReadData;
	logic wbValid;
	mipsPkg::wbPort_t wbInfo;

	mipsPkg::word_t imem [ImemWords];
	mipsPkg::word_t dmem [DmemWords];

	int errorCount;
	int retireCount;
	int storeCount;
	int cyclesOut;
	int waitCycles;

	// distinct data memory fill per word
	function automatic mipsPkg::word_t fillWord(input int idx);
		return (32'h9E37_79B9 * mipsPkg::word_t'(idx + 1)) ^ 32'h0F0F_0000;
	endfunction

	`include "isaModel.svh"

	mipsPipeline mipsPipeline_i (
		.clk           (clk),
		.rstN          (rstN),
		.imemAddr      (imemAddr),
		.imemData      (imemData),
		.dmemAddr      (dmemAddr),
		.dmemWriteData (dmemWriteData),
		.dmemWe        (dmemWe),
		.dmemReadData  (dmemReadData),
		.wbValid       (wbValid),
		.wbInfo        (wbInfo)
	);

	// ==================================================
	// clock and memories
	// ==================================================
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// both memories answer combinationally
	assign imemData = (imemAddr < ImemWords * 4) ? imem[imemAddr[9:2]] : '0;
	assign dmemReadData = dmem[dmemAddr[7:2]];

	always @(posedge clk) begin
		if (rstN && (dmemWe === 1'b1)) begin
			dmem[dmemAddr[7:2]] <= dmemWriteData;
		end
	end

	// ==================================================
	// program generation
	// ==================================================
	function automatic mipsPkg::word_t encR(
		input logic [5:0] funct,
		input logic [4:0] rs,
		input logic [4:0] rt,
		input logic [4:0] rd,
		input logic [4:0] shamt
	);
		return {`MIPS_OP_RTYPE, rs, rt, rd, shamt, funct};
	endfunction

	function automatic mipsPkg::word_t encI(
		input logic [5:0]  op,
		input logic [4:0]  rs,
		input logic [4:0]  rt,
		input logic [15:0] imm
	);
		return {op, rs, rt, imm};
	endfunction

	task automatic genProgram();
		int kind;
		int offset;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sh;
		logic [15:0] imm;
		logic [15:0] memOff;
		logic prevBranch;
		prevBranch = 1'b0;
		// padding is all nops
		for (int i = 0; i < ImemWords; i++) begin
			imem[i] = '0;
		end
		for (int i = 0; i < ProgLen; i++) begin
			// r0..r7 so that r0 also shows up as a destination
			rs = 5'($urandom % 8);
			rt = 5'($urandom % 8);
			rd = 5'($urandom % 8);
			sh = 5'($urandom % 32);
			imm = 16'($urandom);
			// word-aligned r0-based offset
			memOff = {8'd0, 6'($urandom % 64), 2'b00};
			kind = $urandom % 16;
			// no branch in a delay slot
			if (prevBranch && (kind >= 14)) begin
				kind = 9;
			end
			prevBranch = (kind >= 14);
			case (kind)
				0: imem[i] = encR(`MIPS_FN_ADDU, rs, rt, rd, 5'd0);
				1: imem[i] = encR(`MIPS_FN_SUBU, rs, rt, rd, 5'd0);
				2: imem[i] = encR(`MIPS_FN_AND, rs, rt, rd, 5'd0);
				3: imem[i] = encR(`MIPS_FN_OR, rs, rt, rd, 5'd0);
				4: imem[i] = encR(`MIPS_FN_XOR, rs, rt, rd, 5'd0);
				5: imem[i] = encR(`MIPS_FN_NOR, rs, rt, rd, 5'd0);
				6: imem[i] = encR(`MIPS_FN_SLT, rs, rt, rd, 5'd0);
				7: imem[i] = encR(`MIPS_FN_SLTU, rs, rt, rd, 5'd0);
				8: imem[i] = encR(($urandom % 2) ? `MIPS_FN_SLL : `MIPS_FN_SRL, 5'd0, rt, rd, sh);
				9: imem[i] = encI(`MIPS_OP_ADDIU, rs, rd, imm);
				10: imem[i] = encI(($urandom % 2) ? `MIPS_OP_ANDI : `MIPS_OP_ORI, rs, rd, imm);
				11: imem[i] = encI(`MIPS_OP_LUI, 5'd0, rd, imm);
				12: imem[i] = encI(`MIPS_OP_LW, 5'd0, rd, memOff);
				13: imem[i] = encI(`MIPS_OP_SW, 5'd0, rt, memOff);
				default: begin
					// forward by 1..4
					offset = 1 + ($urandom % 4);
					// half of them compare a reg with itself
					if ($urandom % 2) begin
						rt = rs;
					end
					imem[i] = encI(($urandom % 2) ? `MIPS_OP_BEQ : `MIPS_OP_BNE,
						rs, rt, 16'(offset));
				end
			endcase
		end
	endtask

	// ==================================================
	// checking
	// ==================================================
	task automatic reportMismatch(
		input string          testName,
		input mipsPkg::word_t expected,
		input mipsPkg::word_t actual
	);
		$display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", testName, expected, actual);
		errorCount++;
	endtask

	// compare the next wbValid pulse with the model
	task automatic verifyRetirement();
		mipsPkg::wbPort_t want;
		if (wbInfo.dest == '0) begin
			$display("register 0 write retired from pc 0x%08h", wbInfo.pc);
			errorCount++;
		end
		if (expRetQ.size() == 0) begin
			$display("retirement from pc 0x%08h when the model expects none", wbInfo.pc);
			errorCount++;
		end else begin
			want = expRetQ.pop_front();
			if (wbInfo.pc !== want.pc) begin
				reportMismatch($sformatf("retire %0d pc", retireCount), want.pc, wbInfo.pc);
			end
			if (wbInfo.dest !== want.dest) begin
				reportMismatch($sformatf("retire %0d dest", retireCount),
					32'(want.dest), 32'(wbInfo.dest));
			end
			if (wbInfo.data !== want.data) begin
				reportMismatch($sformatf("retire %0d data", retireCount), want.data, wbInfo.data);
			end
			retireCount++;
		end
	endtask

	task automatic compareStore();
		storeRec_t want;
		if (expStoreQ.size() == 0) begin
			$display("store to 0x%08h when the model expects none", dmemAddr);
			errorCount++;
		end else begin
			want = expStoreQ.pop_front();
			if (dmemAddr !== want.addr) begin
				reportMismatch($sformatf("store %0d addr", storeCount), want.addr, dmemAddr);
			end
			if (dmemWriteData !== want.data) begin
				reportMismatch($sformatf("store %0d data", storeCount), want.data, dmemWriteData);
			end
			storeCount++;
		end
	endtask

	// outputs sampled mid-cycle
	initial begin
		// reset values load on the first rising edge
		@(posedge clk);
		forever begin
			@(negedge clk);
			if (!rstN) begin
				cyclesOut = 0;
				if (wbValid !== 1'b0) begin
					reportMismatch("reset wbValid", 32'd0, 32'(wbValid));
				end
				if (dmemWe !== 1'b0) begin
					reportMismatch("reset dmemWe", 32'd0, 32'(dmemWe));
				end
				if (imemAddr !== `MIPS_RESET_PC) begin
					reportMismatch("reset imemAddr", `MIPS_RESET_PC, imemAddr);
				end
			end else begin
				cyclesOut++;
				// nothing reaches memory or writeback this early
				if ((cyclesOut < 3) && (wbValid !== 1'b0)) begin
					reportMismatch("fill wbValid", 32'd0, 32'(wbValid));
				end
				if ((cyclesOut < 3) && (dmemWe !== 1'b0)) begin
					reportMismatch("fill dmemWe", 32'd0, 32'(dmemWe));
				end
				if (wbValid === 1'b1) begin
					verifyRetirement();
				end
				if (dmemWe === 1'b1) begin
					compareStore();
				end
			end
		end
	end

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		rstN = 1'b0;
		errorCount = 0;
		retireCount = 0;
		storeCount = 0;
		cyclesOut = 0;
		waitCycles = 0;
		void'($urandom(70070));
		genProgram();
		for (int w = 0; w < DmemWords; w++) begin
			dmem[w] = fillWord(w);
		end
		runModel();
		$display("model: %0d retirements, %0d stores", expRetQ.size(), expStoreQ.size());

		// four rising edges in reset, released on a falling edge
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstN <= 1'b1;

		// run until the model's last retirement and store are seen
		while (((expRetQ.size() != 0) || (expStoreQ.size() != 0)) && (waitCycles < Timeout)) begin
			@(posedge clk);
			waitCycles++;
		end
		if ((expRetQ.size() != 0) || (expStoreQ.size() != 0)) begin
			$display("timeout: pipeline stopped after %0d cycles", waitCycles);
			$display("timeout: %0d retirements and %0d stores still pending",
				expRetQ.size(), expStoreQ.size());
			errorCount++;
		end

		$display("errors: %0d, retired: %0d, stores: %0d, cycles: %0d",
			errorCount, retireCount, storeCount, waitCycles);
		if (errorCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
+incdir+testbench
hdl/mipsPkg.sv
hdl/controlDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/hazardUnit.sv
hdl/mipsPipeline.sv
testbench/mipsPipelineTb.sv

// ==== Bender.yml ====
package:
  name: mips_pipeline

sources:
  # shared types
  - include_dirs:
      - hdl
    files:
      - hdl/mipsPkg.sv
  # core
  - include_dirs:
      - hdl
    files:
      - hdl/controlDecoder.sv
      - hdl/regFile.sv
      - hdl/alu.sv
      - hdl/hazardUnit.sv
      - hdl/mipsPipeline.sv
  # testbench
  - target: test
    include_dirs:
      - hdl
      - testbench
    files:
      - testbench/mipsPipelineTb.sv
